// File: agent_settings.svh
// slave agent settings
// widths, bytes per word and queue depth shared by the package and by
// every block of the packet-to-memory-mapped slave agent
`ifndef AGENT_SETTINGS_SVH
`define AGENT_SETTINGS_SVH

// data path of the packets and of the master port
`define AGENT_DATA_W 32

// byte address carried in packets and driven on the master port
`define AGENT_ADDR_W 32

// bytes per data word, also the width of the byte-enables
`define AGENT_SYMBOLS 4

// source and destination id fields of the interconnect
`define AGENT_ID_W 3

// byte count of a packet, wide enough for the largest compressed read
`define AGENT_BYTE_CNT_W 6

// burstcount width of the memory-mapped master port
`define AGENT_BURSTCOUNT_W 4

// entries in the response-token queue
`define AGENT_FIFO_DEPTH 4

`endif

// File: agent_pkg.sv
// slave agent types
// packet layouts on the command and response sides, the master-port
// bundles, the entries of the two internal queues and the enums
package agent_pkg;

`include "agent_settings.svh"

   // ----------------------------------------------------------------------
   // encodings
   // ----------------------------------------------------------------------

   // kind of transaction carried by a command, echoed in the response
   typedef enum logic [1:0] {
      READ,
      COMPRESSED_READ,
      WRITE_POSTED,
      WRITE_NONPOSTED
   } trans_kind_e;

   // response status, same encoding as on the memory-mapped port
   typedef enum logic [1:0] {
      OKAY,
      RESERVED,
      SLVERR,
      DECERR
   } resp_status_e;

   // burst uncompressor, waiting for a token or part way through one
   typedef enum logic {
      IDLE,
      IN_BURST
   } uncomp_state_e;

   // ----------------------------------------------------------------------
   // packets
   // ----------------------------------------------------------------------

   typedef struct packed {
      trans_kind_e                  kind;
      logic                         lock;
      logic                         debugaccess;
      logic [`AGENT_ID_W-1:0]       src_id;
      logic [`AGENT_ID_W-1:0]       dest_id;
      logic [`AGENT_BYTE_CNT_W-1:0] byte_cnt;
      logic [`AGENT_SYMBOLS-1:0]    byteen;
      logic [`AGENT_ADDR_W-1:0]     addr;
      logic [`AGENT_DATA_W-1:0]     data;
   } cmd_pkt_t;

   typedef struct packed {
      trans_kind_e                  kind;
      logic [`AGENT_ID_W-1:0]       src_id;
      logic [`AGENT_ID_W-1:0]       dest_id;
      logic [`AGENT_BYTE_CNT_W-1:0] byte_cnt;
      logic [`AGENT_SYMBOLS-1:0]    byteen;
      logic [`AGENT_ADDR_W-1:0]     addr;
      resp_status_e                 status;
      logic [`AGENT_DATA_W-1:0]     data;
   } rsp_pkt_t;

   // ----------------------------------------------------------------------
   // memory-mapped master port
   // ----------------------------------------------------------------------

   typedef struct packed {
      logic                           read;
      logic                           write;
      logic                           lock;
      logic                           debugaccess;
      logic [`AGENT_ADDR_W-1:0]       address;
      logic [`AGENT_BURSTCOUNT_W-1:0] burstcount;
      logic [`AGENT_SYMBOLS-1:0]      byteenable;
      logic [`AGENT_DATA_W-1:0]       writedata;
   } mm_cmd_t;

   typedef struct packed {
      logic                     readdatavalid;
      resp_status_e             status;
      logic [`AGENT_DATA_W-1:0] readdata;
   } mm_rsp_t;

   // ----------------------------------------------------------------------
   // queue entries
   // ----------------------------------------------------------------------

   // ids are stored already swapped, so the response side copies them as is
   typedef struct packed {
      trans_kind_e                  kind;
      logic                         synth;
      logic [`AGENT_ID_W-1:0]       src_id;
      logic [`AGENT_ID_W-1:0]       dest_id;
      logic [`AGENT_BYTE_CNT_W-1:0] byte_cnt;
      logic [`AGENT_SYMBOLS-1:0]    byteen;
      logic [`AGENT_ADDR_W-1:0]     addr;
   } rsp_token_t;

   typedef struct packed {
      resp_status_e             status;
      logic [`AGENT_DATA_W-1:0] data;
   } rdata_word_t;

endpackage

// File: cmd_translator.sv
// command translator
// turns each single-beat command packet into a read or write on the
// memory-mapped master port and records a response token for it
`timescale 1ns/1ns

`include "agent_settings.svh"

module cmd_translator
   import agent_pkg::*;
(
   input  logic       cp_valid,
   input  cmd_pkt_t   cp_data,
   output logic       cp_ready,
   input  logic       token_full,
   output mm_cmd_t    m0_cmd,
   input  logic       m0_waitrequest,
   output logic       token_push,
   output rsp_token_t token
);

   // low address bits that select a byte inside a word
   localparam int MASK_BITS = $clog2(`AGENT_SYMBOLS);
   localparam logic [`AGENT_BYTE_CNT_W-1:0] WORD_BYTES =
      `AGENT_BYTE_CNT_W'(`AGENT_SYMBOLS);

   logic                     is_read;
   logic                     is_nonposted;
   logic                     suppress;
   logic                     mm_read;
   logic                     mm_write;
   logic [`AGENT_ADDR_W-1:0] aligned_addr;

   // ----------------------------------------------------------------------
   // decode
   // ----------------------------------------------------------------------

   assign is_read      = (cp_data.kind == READ) || (cp_data.kind == COMPRESSED_READ);
   assign is_nonposted = (cp_data.kind == WRITE_NONPOSTED);

   // a read with no byte lane enabled never reaches the memory, the
   // response side makes up its answer instead
   assign suppress = is_read && (cp_data.byteen == '0);

   // the memory only ever sees word-aligned addresses
   assign aligned_addr = {cp_data.addr[`AGENT_ADDR_W-1:MASK_BITS], {MASK_BITS{1'b0}}};

   // a suppressed read does not wait on the memory, but every command
   // waits for room in the token queue, posted writes included
   assign cp_ready = (!m0_waitrequest || suppress) && !token_full;

   // ----------------------------------------------------------------------
   // master port
   // ----------------------------------------------------------------------

   assign mm_read  = cp_valid && is_read && !suppress && !token_full;
   assign mm_write = cp_valid && !is_read && !token_full;

   always_comb begin
      m0_cmd.read        = mm_read;
      m0_cmd.write       = mm_write;
      // lock is only meaningful while a transfer is actually presented
      m0_cmd.lock        = cp_valid && cp_data.lock && (mm_read || mm_write);
      m0_cmd.debugaccess = cp_data.debugaccess;
      m0_cmd.address     = aligned_addr;
      m0_cmd.byteenable  = cp_data.byteen;
      m0_cmd.writedata   = cp_data.data;
      // single reads and writes move one word
      m0_cmd.burstcount  = `AGENT_BURSTCOUNT_W'(1);
      if (cp_data.kind == COMPRESSED_READ) begin
         // a compressed read asks for its whole byte count in words
         m0_cmd.burstcount = `AGENT_BURSTCOUNT_W'(cp_data.byte_cnt >> MASK_BITS);
      end
   end

   // ----------------------------------------------------------------------
   // response token
   // ----------------------------------------------------------------------

   // posted writes leave no trace, everything else gets exactly one token
   assign token_push = cp_valid && cp_ready && (is_read || is_nonposted);

   always_comb begin
      token.kind     = cp_data.kind;
      token.synth    = suppress || is_nonposted;
      // the response travels back, so source and destination trade places
      token.src_id   = cp_data.dest_id;
      token.dest_id  = cp_data.src_id;
      // anything but a compressed read answers with a single word
      token.byte_cnt = (cp_data.kind == COMPRESSED_READ) ? cp_data.byte_cnt : WORD_BYTES;
      token.byteen   = cp_data.byteen;
      token.addr     = aligned_addr;
   end

   // the uncompressor counts down in whole words and stops at one word, so
   // a compressed read must carry a nonzero whole number of words
   always_comb begin
      if (cp_valid && cp_ready && (cp_data.kind == COMPRESSED_READ)) begin
         assert #0 ((cp_data.byte_cnt != '0) && (cp_data.byte_cnt[MASK_BITS-1:0] == '0))
            else $error("compressed read byte count is not a whole number of words");
      end
   end

endmodule

// File: rsp_fifo.sv
// response queue
// small circular buffer holding response tokens or returned read words;
// a pushed entry shows at the head one edge later
`timescale 1ns/1ns

module rsp_fifo #(
   parameter type ENTRY_T = logic,
   parameter int  DEPTH   = 4
) (
   input  logic   clk,
   input  logic   reset,
   input  logic   push,
   input  ENTRY_T push_data,
   input  logic   pop,
   output ENTRY_T pop_data,
   output logic   full,
   output logic   empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

   ENTRY_T           mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign full     = (count == CNT_W'(DEPTH));
   assign empty    = (count == '0);
   assign pop_data = mem[rd_ptr];

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // each accepted push lands in the slot under the write pointer
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leave the count alone
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   // the producers upstream are throttled so that they never outrun us
   assert property (@(posedge clk) disable iff (reset) full |-> !push)
      else $error("push into a full queue");

   assert property (@(posedge clk) disable iff (reset) empty |-> !pop)
      else $error("pop from an empty queue");

endmodule

// File: burst_uncompressor.sv
// burst uncompressor
// walks one response token out as one beat per data word, stepping the
// address up and the remaining byte count down on every accepted beat
`timescale 1ns/1ns

`include "agent_settings.svh"

module burst_uncompressor
   import agent_pkg::*;
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         token_valid,
   input  rsp_token_t                   token,
   input  logic                         beat_ready,
   output logic                         beat_valid,
   output logic [`AGENT_ADDR_W-1:0]     beat_addr,
   output logic [`AGENT_BYTE_CNT_W-1:0] beat_byte_cnt,
   output logic                         beat_first,
   output logic                         beat_last,
   output logic                         token_done
);

   localparam logic [`AGENT_BYTE_CNT_W-1:0] WORD_BYTES =
      `AGENT_BYTE_CNT_W'(`AGENT_SYMBOLS);
   localparam logic [`AGENT_ADDR_W-1:0] ADDR_STEP = `AGENT_ADDR_W'(`AGENT_SYMBOLS);

   uncomp_state_e                state;
   logic [`AGENT_ADDR_W-1:0]     run_addr;
   logic [`AGENT_BYTE_CNT_W-1:0] rem_cnt;
   logic                         beat_taken;

   // ----------------------------------------------------------------------
   // current beat
   // ----------------------------------------------------------------------

   // the first beat comes straight off the token, later ones from the
   // running registers
   always_comb begin
      if (state == IDLE) begin
         beat_addr     = token.addr;
         beat_byte_cnt = token.byte_cnt;
         beat_first    = 1'b1;
      end else begin
         beat_addr     = run_addr;
         beat_byte_cnt = rem_cnt;
         beat_first    = 1'b0;
      end
   end

   // the builder already holds token_valid low until the beat can be filled
   assign beat_valid = token_valid;

   // one word left means this is the closing beat of the burst
   assign beat_last  = (beat_byte_cnt <= WORD_BYTES);
   assign beat_taken = beat_valid && beat_ready;
   assign token_done = beat_taken && beat_last;

   // ----------------------------------------------------------------------
   // burst progress
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= IDLE;
      end else if (beat_taken) begin
         state <= beat_last ? IDLE : IN_BURST;
      end
   end

   // address and remaining count of the beat after the one just taken
   always_ff @(posedge clk) begin
      if (beat_taken) begin
         run_addr <= beat_addr + ADDR_STEP;
         rem_cnt  <= beat_byte_cnt - WORD_BYTES;
      end
   end

endmodule

// File: rsp_builder.sv
// response builder
// pairs the token at the head of its queue with returned read data and
// the uncompressor beat, and forms the outgoing response packet;
// suppressed reads and non-posted writes get zero data and OKAY
`timescale 1ns/1ns

`include "agent_settings.svh"

module rsp_builder
   import agent_pkg::*;
(
   input  rsp_token_t                   token,
   input  logic                         token_empty,
   input  rdata_word_t                  rdata,
   input  logic                         rdata_empty,
   input  logic                         beat_valid,
   input  logic [`AGENT_ADDR_W-1:0]     beat_addr,
   input  logic [`AGENT_BYTE_CNT_W-1:0] beat_byte_cnt,
   input  logic                         beat_first,
   input  logic                         beat_last,
   input  logic                         rp_ready,
   output logic                         rp_valid,
   output rsp_pkt_t                     rp_data,
   output logic                         rp_startofpacket,
   output logic                         rp_endofpacket,
   output logic                         rdata_pop,
   output logic                         beat_ready,
   output logic                         token_valid
);

   // ----------------------------------------------------------------------
   // flow control
   // ----------------------------------------------------------------------

   // a synthesized response needs nothing from the memory, a real read
   // beat must wait for its word to land in the readdata queue
   assign token_valid = !token_empty && (token.synth || !rdata_empty);

   // the network is the only thing that can stall an assembled beat
   assign beat_ready = rp_ready;

   assign rp_valid         = beat_valid;
   assign rp_startofpacket = beat_first;
   assign rp_endofpacket   = beat_last;

   // each accepted real read beat consumes exactly one returned word
   assign rdata_pop = beat_valid && rp_ready && !token.synth;

   // ----------------------------------------------------------------------
   // packet fields
   // ----------------------------------------------------------------------

   always_comb begin
      rp_data.kind     = token.kind;
      rp_data.src_id   = token.src_id;
      rp_data.dest_id  = token.dest_id;
      rp_data.byteen   = token.byteen;
      // address and byte count move with each beat of an uncompressed burst
      rp_data.addr     = beat_addr;
      rp_data.byte_cnt = beat_byte_cnt;
      if (token.synth) begin
         rp_data.status = OKAY;
         rp_data.data   = '0;
      end else begin
         rp_data.status = rdata.status;
         rp_data.data   = rdata.data;
      end
   end

endmodule

// File: slave_agent.sv
// slave agent top
// packet-to-memory-mapped slave agent: translator in front, token and
// readdata queues behind the master port, then the uncompressor and the
// builder that send response packets back to the interconnect
`timescale 1ns/1ns

`include "agent_settings.svh"

module slave_agent
   import agent_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     cp_valid,
   input  cmd_pkt_t cp_data,
   output logic     cp_ready,
   output mm_cmd_t  m0_cmd,
   input  logic     m0_waitrequest,
   input  mm_rsp_t  m0_rsp,
   output logic     rp_valid,
   output rsp_pkt_t rp_data,
   output logic     rp_startofpacket,
   output logic     rp_endofpacket,
   input  logic     rp_ready
);

   // every queued token may have a full-length burst of words still to come
   // back, so the readdata queue is sized for the worst case of all of them
   localparam int RDATA_DEPTH = `AGENT_FIFO_DEPTH * (1 << `AGENT_BURSTCOUNT_W);

   rsp_token_t                   token_in;
   rsp_token_t                   token_head;
   logic                         token_push;
   logic                         token_full;
   logic                         token_empty;
   logic                         token_valid;
   logic                         token_done;
   rdata_word_t                  rdata_in;
   rdata_word_t                  rdata_head;
   logic                         rdata_pop;
   logic                         rdata_empty;
   logic                         beat_valid;
   logic                         beat_ready;
   logic [`AGENT_ADDR_W-1:0]     beat_addr;
   logic [`AGENT_BYTE_CNT_W-1:0] beat_byte_cnt;
   logic                         beat_first;
   logic                         beat_last;

   cmd_translator u_translator (
      .cp_valid       (cp_valid),
      .cp_data        (cp_data),
      .cp_ready       (cp_ready),
      .token_full     (token_full),
      .m0_cmd         (m0_cmd),
      .m0_waitrequest (m0_waitrequest),
      .token_push     (token_push),
      .token          (token_in)
   );

   // a token leaves only once the last beat of its response is taken
   rsp_fifo #(.ENTRY_T(rsp_token_t), .DEPTH(`AGENT_FIFO_DEPTH)) token_q (
      .clk (clk), .reset (reset),
      .push (token_push), .push_data (token_in),
      .pop (token_done), .pop_data (token_head),
      .full (token_full), .empty (token_empty)
   );

   assign rdata_in.status = m0_rsp.status;
   assign rdata_in.data   = m0_rsp.readdata;

   // read words arrive in order and are stored as soon as they show up
   rsp_fifo #(.ENTRY_T(rdata_word_t), .DEPTH(RDATA_DEPTH)) rdata_q (
      .clk (clk), .reset (reset),
      .push (m0_rsp.readdatavalid), .push_data (rdata_in),
      .pop (rdata_pop), .pop_data (rdata_head),
      .full (), .empty (rdata_empty)
   );

   burst_uncompressor u_uncompressor (
      .clk (clk), .reset (reset),
      .token_valid (token_valid), .token (token_head),
      .beat_ready (beat_ready), .beat_valid (beat_valid),
      .beat_addr (beat_addr), .beat_byte_cnt (beat_byte_cnt),
      .beat_first (beat_first), .beat_last (beat_last),
      .token_done (token_done)
   );

   rsp_builder u_builder (
      .token (token_head), .token_empty (token_empty),
      .rdata (rdata_head), .rdata_empty (rdata_empty),
      .beat_valid (beat_valid), .beat_addr (beat_addr),
      .beat_byte_cnt (beat_byte_cnt), .beat_first (beat_first),
      .beat_last (beat_last), .rp_ready (rp_ready),
      .rp_valid (rp_valid), .rp_data (rp_data),
      .rp_startofpacket (rp_startofpacket), .rp_endofpacket (rp_endofpacket),
      .rdata_pop (rdata_pop), .beat_ready (beat_ready),
      .token_valid (token_valid)
   );

   // a stalled response beat must not change underneath the network, which
   // relies on both queue heads and the uncompressor holding still together
   assert property (@(posedge clk) disable iff (reset)
      rp_valid && !rp_ready |=> rp_valid && $stable(rp_data))
      else $error("response beat changed while stalled");

endmodule

// File: tb_slave_agent.sv
// slave agent testbench
// replays command packets from the trace file into the agent, answers
// the master port from a memory model and checks every response beat
// against the expected beats of the trace, under random back-pressure
`timescale 1ns/1ns

`include "agent_settings.svh"

module tb_slave_agent
   import agent_pkg::*;
;

   localparam int          HALF_PERIOD  = 20;
   localparam int          RESET_CYCLES = 4;
   localparam int          CYCLES_PER_LINE = 200;
   localparam int          DRAIN_CYCLES = 10;
   localparam logic [31:0] HIGH_BASE    = 32'h0000_8000;

   // expected response beat with its framing
   typedef struct packed {
      rsp_pkt_t pkt;
      logic     sop;
      logic     eop;
   } exp_beat_t;

   logic     clk;
   logic     reset;
   logic     cp_valid;
   cmd_pkt_t cp_data;
   logic     cp_ready;
   mm_cmd_t  m0_cmd;
   logic     m0_waitrequest;
   mm_rsp_t  m0_rsp;
   logic     rp_valid;
   rsp_pkt_t rp_data;
   logic     rp_startofpacket;
   logic     rp_endofpacket;
   logic     rp_ready;

   cmd_pkt_t    commands [$];
   exp_beat_t   expected_beats [$];
   rdata_word_t read_returns [$];
   // byte enables of accepted commands still waiting for their response
   logic [`AGENT_SYMBOLS-1:0] rsp_byteen [$];
   logic [31:0] mem [logic [31:0]];
   logic [31:0] rule;
   int          cmd_idx;
   int          exp_idx;
   int          watchdog_cycles;
   integer      seed;

   slave_agent DUT (
      .clk (clk), .reset (reset),
      .cp_valid (cp_valid), .cp_data (cp_data), .cp_ready (cp_ready),
      .m0_cmd (m0_cmd), .m0_waitrequest (m0_waitrequest), .m0_rsp (m0_rsp),
      .rp_valid (rp_valid), .rp_data (rp_data),
      .rp_startofpacket (rp_startofpacket), .rp_endofpacket (rp_endofpacket),
      .rp_ready (rp_ready)
   );

   always #HALF_PERIOD clk = ~clk;

   // ----------------------------------------------------------------------
   // reporting
   // ----------------------------------------------------------------------

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         fail_now($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected));
      end
   endtask

   // ----------------------------------------------------------------------
   // trace file
   // ----------------------------------------------------------------------

   // C and E lines share nine hex columns, W carries the read-data rule
   task automatic load_trace();
      integer      fd;
      int          n;
      int          n_lines;
      string       line;
      string       body;
      byte         tag;
      logic [31:0] col [9];
      cmd_pkt_t    c;
      exp_beat_t   e;
      n_lines = 0;
      fd = $fopen("slave_agent_trace.txt", "r");
      if (fd == 0) begin
         fail_now("cannot open the trace file slave_agent_trace.txt");
      end
      while ($fgets(line, fd) != 0) begin
         n_lines++;
         tag  = line.getc(0);
         body = line.substr(1, line.len() - 1);
         if (tag == "W") begin
            n = $sscanf(body, "%h", rule);
         end else if (tag == "C" || tag == "E") begin
            n = $sscanf(body, "%h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                        col[3], col[4], col[5], col[6], col[7], col[8]);
            if (n != 9) begin
               fail_now({"malformed trace line: ", line});
            end else if (tag == "C") begin
               c.kind        = trans_kind_e'(col[0][1:0]);
               c.lock        = col[1][0];
               c.debugaccess = col[2][0];
               c.src_id      = col[3][`AGENT_ID_W-1:0];
               c.dest_id     = col[4][`AGENT_ID_W-1:0];
               c.byte_cnt    = col[5][`AGENT_BYTE_CNT_W-1:0];
               c.byteen      = col[6][`AGENT_SYMBOLS-1:0];
               c.addr        = col[7];
               c.data        = col[8];
               commands.push_back(c);
            end else begin
               e.pkt.kind     = trans_kind_e'(col[0][1:0]);
               e.pkt.src_id   = col[1][`AGENT_ID_W-1:0];
               e.pkt.dest_id  = col[2][`AGENT_ID_W-1:0];
               e.pkt.addr     = col[3];
               e.pkt.byte_cnt = col[4][`AGENT_BYTE_CNT_W-1:0];
               e.pkt.status   = resp_status_e'(col[5][1:0]);
               e.pkt.data     = col[6];
               e.pkt.byteen   = '0;
               e.sop          = col[7][0];
               e.eop          = col[8][0];
               expected_beats.push_back(e);
            end
         end
      end
      $fclose(fd);
      watchdog_cycles = CYCLES_PER_LINE * n_lines;
   endtask

   // ----------------------------------------------------------------------
   // memory model
   // ----------------------------------------------------------------------

   // a word never written reads as its own address mixed with the rule
   function automatic logic [31:0] stored_word(input logic [31:0] addr);
      stored_word = mem.exists(addr) ? mem[addr] : (addr ^ rule);
   endfunction

   // a transfer is taken by the memory when waitrequest is low
   task automatic observe_master();
      logic [31:0] addr;
      logic [31:0] word;
      logic [31:0] exp_count;
      logic        is_write;
      rdata_word_t w;
      int          i;
      if (!m0_waitrequest && (m0_cmd.read || m0_cmd.write)) begin
         addr      = m0_cmd.address;
         exp_count = (cp_data.kind == COMPRESSED_READ) ? 32'(cp_data.byte_cnt) / 4 : 1;
         is_write  = (cp_data.kind == WRITE_POSTED) || (cp_data.kind == WRITE_NONPOSTED);
         // the memory must never take a transfer that the packet side drops
         check_value("cp_ready", cp_ready, 1);
         check_value("m0_cmd.write", m0_cmd.write, is_write);
         check_value("m0_cmd.address", addr, {cp_data.addr[31:2], 2'b00});
         check_value("m0_cmd.byteenable", m0_cmd.byteenable, cp_data.byteen);
         check_value("m0_cmd.lock", m0_cmd.lock, cp_data.lock);
         check_value("m0_cmd.debugaccess", m0_cmd.debugaccess, cp_data.debugaccess);
         if (m0_cmd.write) begin
            check_value("m0_cmd.writedata", m0_cmd.writedata, cp_data.data);
            word = stored_word(addr);
            for (i = 0; i < `AGENT_SYMBOLS; i++) begin
               if (m0_cmd.byteenable[i]) begin
                  word[8*i +: 8] = m0_cmd.writedata[8*i +: 8];
               end
            end
            mem[addr] = word;
         end else if (m0_cmd.byteenable == '0) begin
            fail_now("a read with all byte enables clear reached the master port");
         end else begin
            check_value("m0_cmd.burstcount", m0_cmd.burstcount, exp_count);
            // words of the burst go back one per cycle from the next cycle on
            for (i = 0; i < int'(m0_cmd.burstcount); i++) begin
               w.status = ((addr + 32'(4 * i)) >= HIGH_BASE) ? SLVERR : OKAY;
               w.data   = stored_word(addr + 32'(4 * i));
               read_returns.push_back(w);
            end
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // scoreboard
   // ----------------------------------------------------------------------

   task automatic check_beat();
      exp_beat_t e;
      if (exp_idx >= expected_beats.size()) begin
         fail_now("a response beat arrived with no expected beat left in the trace");
      end else if (rsp_byteen.size() == 0) begin
         fail_now("a response beat arrived with no accepted command waiting for it");
      end else begin
         e = expected_beats[exp_idx];
         check_value("rp_data.kind", rp_data.kind, e.pkt.kind);
         check_value("rp_data.src_id", rp_data.src_id, e.pkt.src_id);
         check_value("rp_data.dest_id", rp_data.dest_id, e.pkt.dest_id);
         check_value("rp_data.addr", rp_data.addr, e.pkt.addr);
         check_value("rp_data.byte_cnt", rp_data.byte_cnt, e.pkt.byte_cnt);
         check_value("rp_data.byteen", rp_data.byteen, rsp_byteen[0]);
         check_value("rp_data.status", rp_data.status, e.pkt.status);
         check_value("rp_data.data", rp_data.data, e.pkt.data);
         check_value("rp_startofpacket", rp_startofpacket, e.sop);
         check_value("rp_endofpacket", rp_endofpacket, e.eop);
         if (e.eop) begin
            rsp_byteen.delete(0);
         end
         exp_idx++;
      end
   endtask

   // handshakes are judged on the values present just before the edge
   always @(posedge clk) begin
      if (!reset) begin
         observe_master();
         if (cp_valid && cp_ready) begin
            cmd_idx++;
            // every command but a posted write is answered with its byte enables
            if (cp_data.kind != WRITE_POSTED) begin
               rsp_byteen.push_back(cp_data.byteen);
            end
         end
         if (rp_valid && rp_ready) begin
            check_beat();
         end
      end
   end

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------

   task automatic drive_inputs();
      rdata_word_t w;
      if (cmd_idx < commands.size()) begin
         cp_valid = 1'b1;
         cp_data  = commands[cmd_idx];
      end else begin
         cp_valid = 1'b0;
         cp_data  = '0;
      end
      m0_waitrequest = (($random(seed) & 3) == 0);
      rp_ready       = (($random(seed) & 7) > 2);
      if (read_returns.size() > 0) begin
         w = read_returns.pop_front();
         m0_rsp.readdatavalid = 1'b1;
         m0_rsp.status        = w.status;
         m0_rsp.readdata      = w.data;
      end else begin
         m0_rsp = '0;
      end
   endtask

   initial begin
      clk             = 1'b0;
      reset           = 1'b1;
      cp_valid        = 1'b0;
      cp_data         = '0;
      m0_waitrequest  = 1'b0;
      m0_rsp          = '0;
      rp_ready        = 1'b0;
      rule            = '0;
      cmd_idx         = 0;
      exp_idx         = 0;
      watchdog_cycles = 0;
      seed            = 32'ha83c;
      load_trace();
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      while ((cmd_idx < commands.size()) || (exp_idx < expected_beats.size())) begin
         drive_inputs();
         @(negedge clk);
      end
      // a few idle cycles so that any stray extra beat is caught
      repeat (DRAIN_CYCLES) begin
         drive_inputs();
         @(negedge clk);
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      fail_now("watchdog expired before all expected response beats arrived");
   end

endmodule

// File: slave_agent_trace.txt
# C kind lock dbg src dest byte_cnt byteen addr data   (command packet, hex)
# E kind src dest addr byte_cnt status data sop eop    (expected response beat, hex)
# W constant xored with the address to give the content of an unwritten word
W c3a50000
# posted write, then a single read of the same word
C 2 0 0 1 5 04 f 00000100 12345678
C 0 0 0 1 5 04 f 00000100 00000000
E 0 5 1 00000100 04 0 12345678 1 1
# compressed read of four words from an unaligned base
C 1 0 0 2 6 10 f 00000206 00000000
E 1 6 2 00000204 10 0 c3a50204 1 0
E 1 6 2 00000208 0c 0 c3a50208 0 0
E 1 6 2 0000020c 08 0 c3a5020c 0 0
E 1 6 2 00000210 04 0 c3a50210 0 1
# read with every byte enable clear never reaches the memory
C 0 0 0 3 4 04 0 00000300 00000000
E 0 4 3 00000300 04 0 00000000 1 1
# locked non-posted write answers once, the posted write does not
C 3 1 0 4 2 04 f 00000400 a5a5a5a5
E 3 2 4 00000400 04 0 00000000 1 1
C 2 0 1 4 2 04 3 00000404 0000beef
C 0 0 0 4 2 04 f 00000404 00000000
E 0 2 4 00000404 04 0 c3a5beef 1 1
# reads above the decoded range come back with a slave error
C 0 0 0 5 1 04 f 00008000 00000000
E 0 1 5 00008000 04 2 c3a58000 1 1
C 1 0 0 5 1 08 f 00009ff8 00000000
E 1 1 5 00009ff8 08 2 c3a59ff8 1 0
E 1 1 5 00009ffc 04 2 c3a59ffc 0 1
# back-to-back mix that fills the token queue under stalls
C 3 0 0 6 7 04 f 00000500 0badf00d
E 3 7 6 00000500 04 0 00000000 1 1
C 0 0 0 6 7 04 f 00000500 00000000
E 0 7 6 00000500 04 0 0badf00d 1 1
C 1 0 0 7 0 08 f 00000508 00000000
E 1 0 7 00000508 08 0 c3a50508 1 0
E 1 0 7 0000050c 04 0 c3a5050c 0 1
C 0 0 0 7 0 04 0 00000510 00000000
E 0 0 7 00000510 04 0 00000000 1 1
C 0 0 0 0 3 04 f 00000103 00000000
E 0 3 0 00000100 04 0 12345678 1 1
C 1 0 0 1 2 10 f 00000700 00000000
E 1 2 1 00000700 10 0 c3a50700 1 0
E 1 2 1 00000704 0c 0 c3a50704 0 0
E 1 2 1 00000708 08 0 c3a50708 0 0
E 1 2 1 0000070c 04 0 c3a5070c 0 1
C 0 0 0 2 1 04 f 00008004 00000000
E 0 1 2 00008004 04 2 c3a58004 1 1

// File: build.f
+incdir+.
agent_pkg.sv
cmd_translator.sv
rsp_fifo.sv
burst_uncompressor.sv
rsp_builder.sv
slave_agent.sv
tb_slave_agent.sv

// File: Makefile
TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_slave_agent
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
